// File: common/fcvtPkg.sv
package fcvtPkg;

    //////////////////////////////////////////////////
    // widths and biases
    //////////////////////////////////////////////////

    localparam int XLEN   = 64;   // integer register width
    localparam int BIAS_D = 1023; // double exponent bias
    localparam int BIAS_S = 127;  // single exponent bias

    typedef logic [XLEN-1:0] dataT;     // raw register word, int or fp
    typedef logic [10:0]     expT;      // biased exponent
    typedef logic [52:0]     manT;      // mantissa incl hidden bit
    typedef logic [12:0]     shiftCntT; // unbiased exp / shift amount, signed meaning

    // operation encoding {long, unsigned, to int}
    // e.g. fcvt.w.s = 001, fcvt.s.lu = 110
    typedef struct packed {
        logic isLong;     // 64 bit integer side
        logic isUnsigned; // unsigned integer side
        logic toInt;      // 1 = fp to int
    } cvtOpT;

    typedef enum logic [2:0] {
        RNE = 3'd0, // nearest, ties to even
        RTZ = 3'd1, // toward zero
        RDN = 3'd2, // toward -inf
        RUP = 3'd3, // toward +inf
        RMM = 3'd4  // nearest, ties to max magnitude
    } roundModeT;

    typedef struct packed {
        logic invalid;
        logic divZero;   // never set here
        logic overflow;  // never set here
        logic underflow; // never set here
        logic inexact;
    } flagsT;

    // classified fp operand
    typedef struct packed {
        logic sgn;
        expT  exp;
        manT  man;
        logic isZero;
        logic isNaN;
        logic isInf;
        logic isDenorm;
    } fpOperandT;

    //////////////////////////////////////////////////
    // stage boundaries
    //////////////////////////////////////////////////

    // stage 1 -> 2
    typedef struct packed {
        logic      valid;
        cvtOpT     op;
        roundModeT frm;
        logic      fmt;     // 1 = double
        fpOperandT operand;
        dataT      intSrc;
    } unpackStageT;

    // stage 2 -> 3
    typedef struct packed {
        logic          valid;
        cvtOpT         op;
        logic          fmt;
        logic          sgn;        // fp operand sign
        logic          isZero;
        logic          isNaN;
        logic          isInf;
        logic          intSgn;     // int source sign
        shiftCntT      shiftCnt;
        logic [XLEN:0] roundedInt; // magnitude + carry out
        dataT          fpPacked;   // {sign, exp, frac} unboxed
        logic          guard;
        logic          round;
        logic          sticky;
        logic          plus1;
        logic          calcPlus1;
    } roundStageT;

endpackage

// File: design/fpUnpack.sv
`timescale 1ns/1ps

module fpUnpack
    import fcvtPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        inValid,
    input  cvtOpT       op,
    input  roundModeT   frm,
    input  logic        fmt,
    input  dataT        fpIn,
    input  dataT        intIn,
    output unpackStageT stage1
);

    logic [31:0] spWord;     // single operand after box check
    logic        sgn;
    expT         rawExp;
    logic [51:0] rawFrac;    // frac left aligned
    logic        expAllOnes;
    logic        expZero;
    logic        fracZero;
    unpackStageT s1Next;

    // unboxed single reads as canonical qNaN
    assign spWord = (&fpIn[63:32]) ? fpIn[31:0] : 32'h7fc0_0000;

    //////////////////////////////////////////////////
    // field select
    //////////////////////////////////////////////////

    always_comb begin
        if (fmt) begin
            sgn        = fpIn[63];
            rawExp     = fpIn[62:52];
            rawFrac    = fpIn[51:0];
            expAllOnes = &fpIn[62:52];
        end else begin
            sgn        = spWord[31];
            rawExp     = {3'b0, spWord[30:23]};  // widen to 11 bits
            rawFrac    = {spWord[22:0], 29'b0};  // frac at the top
            expAllOnes = &spWord[30:23];
        end
    end

    assign expZero  = (rawExp == '0);
    assign fracZero = (rawFrac == '0);

    // classify and bundle with controls
    always_comb begin
        s1Next                  = '0;
        s1Next.valid            = inValid;
        s1Next.op               = op;
        s1Next.frm              = frm;
        s1Next.fmt              = fmt;
        s1Next.intSrc           = intIn;
        s1Next.operand.sgn      = sgn;
        s1Next.operand.exp      = rawExp;
        s1Next.operand.man      = {~expZero, rawFrac}; // hidden bit
        s1Next.operand.isZero   = expZero & fracZero;
        s1Next.operand.isDenorm = expZero & ~fracZero;
        s1Next.operand.isInf    = expAllOnes & fracZero;
        s1Next.operand.isNaN    = expAllOnes & ~fracZero;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage1 <= '0;
        end else begin
            stage1 <= s1Next;
        end
    end

endmodule

// File: fcvt/cvtShiftRound.sv
`timescale 1ns/1ps

module cvtShiftRound
    import fcvtPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  unpackStageT stage1,
    output roundStageT  stage2
);

    cvtOpT              op;
    fpOperandT          x;           // fp operand
    logic               fmt;
    expT                bias;        // bias for selected precision
    logic [7:0]         subBits;     // width of int source
    shiftCntT           expVal;      // unbiased exponent
    dataT               intAligned;  // int source at the top
    dataT               posInt;      // |int source|
    logic               resSgn;      // int source sign
    logic [6:0]         lzCnt;       // leading zeros of posInt
    logic [6:0]         lzResP;      // shift that drops the leading one
    logic               noOne;
    expT                tmpExp;      // biased exp of fp result
    shiftCntT           shiftCnt;
    logic [XLEN+51:0]   shiftVal;
    logic [XLEN+51:0]   shiftedTmp;
    logic [XLEN+1:0]    shiftedMan;  // integer part + guard + round
    logic               guard;
    logic               round;
    logic               lsb;
    logic               sticky;
    logic               srcSgn;      // sign used by directed modes
    logic               calcPlus1;
    logic               plus1;
    logic [XLEN:0]      roundedTmp;
    logic [62:0]        expFrac;     // rounded {exp, frac}
    roundStageT         s2Next;

    assign op  = stage1.op;
    assign x   = stage1.operand;
    assign fmt = stage1.fmt;

    assign bias    = fmt ? expT'(BIAS_D) : expT'(BIAS_S);
    assign subBits = op.isLong ? 8'd64 : 8'd32;

    // denormals count as 1 - bias
    assign expVal = {2'b0, x.exp} - {2'b0, bias} + {12'b0, x.isDenorm};

    //////////////////////////////////////////////////
    // int source prep (int -> fp)
    //////////////////////////////////////////////////

    assign intAligned = op.isLong ? stage1.intSrc : {stage1.intSrc[31:0], 32'b0};
    assign resSgn     = ~op.isUnsigned & intAligned[XLEN-1];
    assign posInt     = resSgn ? -intAligned : intAligned;

    // leading one search, last hit is the highest set bit
    always_comb begin
        lzCnt = 7'd64;                           // nothing found
        for (int k = 0; k < XLEN; k++) begin
            if (posInt[k]) begin
                lzCnt = 7'(XLEN - 1 - k);
            end
        end
    end

    assign noOne  = lzCnt[6];
    assign lzResP = lzCnt + 7'd1;

    // zero source gives zero exponent
    assign tmpExp = noOne ? '0 : bias + expT'(subBits) - expT'(lzResP);

    //////////////////////////////////////////////////
    // alignment
    //////////////////////////////////////////////////

    assign shiftCnt = op.toInt ? expVal : {6'b0, lzResP};
    assign shiftVal = op.toInt ? {{(XLEN-1){1'b0}}, x.man} : {posInt, 52'b0};

    always_comb begin
        if (&shiftCnt) begin
            // -1 so one right shift, hidden bit lands on guard
            shiftedTmp = {{XLEN{1'b0}}, x.man[52:1]};
        end else if (shiftCnt[12]) begin
            // far below one, only sticky survives
            shiftedTmp = {{(XLEN+51){1'b0}}, ~x.isZero};
        end else begin
            shiftedTmp = shiftVal << shiftCnt;
        end
    end

    assign shiftedMan = shiftedTmp[XLEN+51:50];

    // sticky window depends on direction and precision
    assign sticky = (|shiftedTmp[49:0])
                  | (&shiftCnt & x.man[0])                        // bit lost by -1 shift
                  | (~op.toInt & |shiftedTmp[62:50])              // below double frac
                  | (~op.toInt & ~fmt & |shiftedTmp[91:63]);      // below single frac

    always_comb begin
        if (op.toInt) begin
            guard = shiftedMan[1];
            round = shiftedMan[0];
            lsb   = shiftedMan[2];
        end else if (fmt) begin
            guard = shiftedMan[13];
            round = shiftedMan[12];
            lsb   = shiftedMan[14];
        end else begin
            guard = shiftedMan[42];
            round = shiftedMan[41];
            lsb   = shiftedMan[43];
        end
    end

    //////////////////////////////////////////////////
    // rounding decision
    //////////////////////////////////////////////////

    assign srcSgn = op.toInt ? x.sgn : resSgn;

    always_comb begin
        case (stage1.frm)
            RNE:     calcPlus1 = guard & (round | sticky | lsb); // tie goes to even
            RTZ:     calcPlus1 = 1'b0;
            RDN:     calcPlus1 = srcSgn;                         // grow negative magnitude
            RUP:     calcPlus1 = ~srcSgn;
            RMM:     calcPlus1 = guard;                          // tie away from zero
            default: calcPlus1 = 1'b0;
        endcase
    end

    // nothing to add when exact
    assign plus1 = calcPlus1 & (guard | round | sticky) & ~(x.isZero & op.toInt);

    // rounded integer magnitude with carry out
    assign roundedTmp = shiftedMan[XLEN+1:2] + {{XLEN{1'b0}}, plus1};

    // carry out of frac bumps the exponent
    always_comb begin
        if (fmt) begin
            expFrac = {tmpExp, shiftedMan[XLEN+1:14]} + {62'b0, plus1};
        end else begin
            expFrac = {{tmpExp, shiftedMan[XLEN+1:43]} + {33'b0, plus1}, 29'b0};
        end
    end

    always_comb begin
        s2Next            = '0;
        s2Next.valid      = stage1.valid;
        s2Next.op         = op;
        s2Next.fmt        = fmt;
        s2Next.sgn        = x.sgn;
        s2Next.isZero     = x.isZero;
        s2Next.isNaN      = x.isNaN;
        s2Next.isInf      = x.isInf;
        s2Next.intSgn     = resSgn;
        s2Next.shiftCnt   = shiftCnt;
        s2Next.roundedInt = roundedTmp;
        s2Next.fpPacked   = {resSgn, expFrac};
        s2Next.guard      = guard;
        s2Next.round      = round;
        s2Next.sticky     = sticky;
        s2Next.plus1      = plus1;
        s2Next.calcPlus1  = calcPlus1;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stage2 <= '0;
        end else begin
            stage2 <= s2Next;
        end
    end

endmodule

// File: fcvt/cvtSaturate.sv
`timescale 1ns/1ps

module cvtSaturate
    import fcvtPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  roundStageT stage2,
    output logic       resValid,
    output dataT       result,
    output flagsT      flags
);

    cvtOpT    op;
    shiftCntT bitsCnt;    // target int width
    dataT     rounded;    // signed rounded value
    dataT     normInt;    // in range result, word sign extended
    dataT     intMax;
    dataT     intMin;
    dataT     intRes;
    dataT     fpRes;
    dataT     resNext;
    logic     roundMsb;   // carry out of rounding
    logic     roundSgn;   // sign bit of target width
    logic     tooBig;     // exponent past target width
    logic     of;
    logic     uf;
    logic     invalid;
    logic     inexact;
    flagsT    flagsNext;

    assign op      = stage2.op;
    assign bitsCnt = op.isLong ? 13'd64 : 13'd32;

    assign rounded  = stage2.sgn ? -stage2.roundedInt[XLEN-1:0] : stage2.roundedInt[XLEN-1:0];
    assign roundMsb = op.isLong ? stage2.roundedInt[XLEN] : stage2.roundedInt[32];
    assign roundSgn = op.isLong ? rounded[XLEN-1] : rounded[31];
    assign tooBig   = $signed(stage2.shiftCnt) >= $signed(bitsCnt);

    //////////////////////////////////////////////////
    // range check
    //////////////////////////////////////////////////

    assign of = (~stage2.sgn & tooBig)
              | (~stage2.sgn & roundSgn & ~op.isUnsigned)            // past signed max
              | (~stage2.sgn & stage2.plus1 & roundMsb
                 & (stage2.shiftCnt == bitsCnt - 13'd1))             // rounded past width
              | (~stage2.sgn & stage2.isInf)
              | stage2.isNaN;

    always_comb begin
        if (op.isUnsigned) begin
            // negative is fine only if it rounds to zero
            uf = (stage2.sgn & ~stage2.isZero & (~stage2.shiftCnt[12] | stage2.calcPlus1))
               | (stage2.sgn & stage2.isInf);
        end else begin
            uf = (stage2.sgn & tooBig)
               | (stage2.sgn & ~roundSgn & ~stage2.shiftCnt[12])    // below signed min
               | (stage2.sgn & stage2.isInf);
        end
    end

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////

    always_comb begin
        if (op.isUnsigned) begin
            intMax = '1;                         // word max sign extends to all ones
            intMin = '0;
        end else if (op.isLong) begin
            intMax = {1'b0, {(XLEN-1){1'b1}}};
            intMin = {1'b1, {(XLEN-1){1'b0}}};
        end else begin
            intMax = {33'b0, {31{1'b1}}};
            intMin = {{33{1'b1}}, 31'b0};
        end
    end

    assign normInt = op.isLong ? rounded : {{32{rounded[31]}}, rounded[31:0]};

    always_comb begin
        if (of) begin
            intRes = intMax;                     // NaN lands here too
        end else if (uf) begin
            intRes = intMin;
        end else begin
            intRes = normInt;
        end
    end

    // single gets boxed with ones
    assign fpRes = stage2.fmt ? {stage2.intSgn, stage2.fpPacked[62:0]}
                              : {32'hffff_ffff, stage2.intSgn, stage2.fpPacked[59:29]};

    assign resNext = op.toInt ? intRes : fpRes;

    // flags, checked after rounding
    assign invalid = op.toInt & (of | uf);
    assign inexact = (stage2.guard | stage2.round | stage2.sticky) & ~invalid;

    always_comb begin
        flagsNext           = '0;
        flagsNext.invalid   = invalid;
        flagsNext.divZero   = 1'b0;
        flagsNext.overflow  = 1'b0;
        flagsNext.underflow = 1'b0;
        flagsNext.inexact   = inexact;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resValid <= 1'b0;
            result   <= '0;
            flags    <= '0;
        end else begin
            resValid <= stage2.valid;
            result   <= resNext;
            flags    <= flagsNext;
        end
    end

endmodule

// File: design/fcvtUnit.sv
`timescale 1ns/1ps

module fcvtUnit
    import fcvtPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      inValid,   // one strobe per op
    input  cvtOpT     op,
    input  roundModeT frm,
    input  logic      fmt,       // 1 = double
    input  dataT      fpIn,      // single in 31:0
    input  dataT      intIn,
    output logic      resValid,
    output dataT      result,
    output flagsT     flags
);

    unpackStageT stage1; // unpack -> shift/round
    roundStageT  stage2; // shift/round -> saturate

    // classify operand
    fpUnpack uUnpack (
        .clk     (clk),
        .rstN    (rstN),
        .inValid (inValid),
        .op      (op),
        .frm     (frm),
        .fmt     (fmt),
        .fpIn    (fpIn),
        .intIn   (intIn),
        .stage1  (stage1)
    );

    // align and round
    cvtShiftRound uShiftRound (
        .clk    (clk),
        .rstN   (rstN),
        .stage1 (stage1),
        .stage2 (stage2)
    );

    // clamp, pack, flags
    cvtSaturate uSaturate (
        .clk      (clk),
        .rstN     (rstN),
        .stage2   (stage2),
        .resValid (resValid),
        .result   (result),
        .flags    (flags)
    );

endmodule

// File: verif/fcvtTb.sv
`timescale 1ns/1ps

module fcvtTb
    import fcvtPkg::*;
();

    localparam flagsT NO_FLAGS     = 5'b00000;
    localparam flagsT INEXACT_ONLY = 5'b00001;
    localparam flagsT INVALID_ONLY = 5'b10000;
    localparam int    DRAIN_LIMIT  = 60;      // cycles allowed for results to come back

    logic      clk = 1'b0;
    logic      rstN;
    logic      inValid;
    cvtOpT     op;
    roundModeT frm;
    logic      fmt;
    dataT      fpIn;
    dataT      intIn;
    logic      resValid;
    dataT      result;
    flagsT     flags;

    dataT        expResQ[$];    // expected results, launch order
    flagsT       expFlagQ[$];
    int          launchQ[$];    // edge that drove each beat
    dataT        expRes;
    flagsT       expFlg;
    int          launchEdge;
    int          edgeCnt = 0;
    int          errCnt = 0;
    int          passCnt = 0;
    int          failCnt = 0;
    bit          timedOut = 1'b0;
    logic [31:0] lcgState = 32'd86;
    real         testVals[7] = '{0.5, -0.5, 1.5, -1.5, 2.5, -2.5, 3.7};

    always #2 clk = ~clk;                    // 4 ns period

    always @(posedge clk) edgeCnt <= edgeCnt + 1;

    fcvtUnit dut (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .op       (op),
        .frm      (frm),
        .fmt      (fmt),
        .fpIn     (fpIn),
        .intIn    (intIn),
        .resValid (resValid),
        .result   (result),
        .flags    (flags)
    );

    //////////////////////////////////////////////////
    // reference helpers
    //////////////////////////////////////////////////

    // 24 upper bits of the LCG state
    function automatic logic [23:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState[31:8];
    endfunction

    // rebias double bits to single, only for values single holds
    function automatic logic [31:0] toSingle(input logic [63:0] d);
        logic [10:0] e;
        e = d[62:52] - 11'd896;              // 1023 - 127
        if (d[62:0] == '0) return {d[63], 31'b0};
        return {d[63], e[7:0], d[51:29]};
    endfunction

    function automatic dataT boxS(input logic [31:0] s);
        return {32'hffff_ffff, s};
    endfunction

    // integer that a real rounds to under each mode
    function automatic longint roundRef(input real r, input roundModeT m);
        longint t;
        longint away;
        real    f;
        real    a;
        t    = $rtoi(r);                     // toward zero
        f    = r - t;
        a    = (f < 0.0) ? -f : f;
        away = (r < 0.0) ? t - 1 : t + 1;
        case (m)
            RTZ: return t;
            RDN: return (f < 0.0) ? t - 1 : t;
            RUP: return (f > 0.0) ? t + 1 : t;
            RMM: return (a >= 0.5) ? away : t;
            default: begin
                if (a > 0.5) return away;
                if (a < 0.5) return t;
                return (t % 2 == 0) ? t : away;  // tie to even
            end
        endcase
    endfunction

    //////////////////////////////////////////////////
    // drive and wait
    //////////////////////////////////////////////////

    task automatic launch(input cvtOpT o, input roundModeT m, input logic f, input dataT fp,
                          input dataT iv, input dataT er, input flagsT ef);
        @(posedge clk);
        inValid <= 1'b1;
        op      <= o;
        frm     <= m;
        fmt     <= f;
        fpIn    <= fp;
        intIn   <= iv;
        expResQ.push_back(er);
        expFlagQ.push_back(ef);
    endtask

    task automatic idle();
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    // exact beat, int -> fp or (when allowed) fp -> int
    task automatic randomBeat(input bit mixDir);
        logic [23:0] r;
        logic [23:0] mag;
        longint      v;
        logic [63:0] d;
        logic [31:0] s;
        cvtOpT       o;
        roundModeT   m;
        r   = nextRand();
        mag = nextRand();                    // below 2^24
        o   = cvtOpT'({r[23], r[22], mixDir & r[21]});
        m   = roundModeT'(r[15:8] % 5);
        v   = (~o.isUnsigned & r[20]) ? -longint'(mag) : longint'(mag);
        d   = $realtobits(real'(v));
        s   = toSingle(d);
        if (o.toInt) begin
            launch(o, m, r[19], r[19] ? d : boxS(s), '0, dataT'(v), NO_FLAGS);
        end else begin
            launch(o, m, r[19], '0, dataT'(v), r[19] ? d : boxS(s), NO_FLAGS);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (expResQ.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (expResQ.size() != 0) begin
            timedOut = 1'b1;
            $display("timeout: %0d results never came back", expResQ.size());
        end
        repeat (4) @(posedge clk);           // idle tail, catches stray resValid
    endtask

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rstN) begin
            assert (!resValid && result == '0 && flags == '0) else begin
                errCnt++;
                $display("outputs not cleared while reset is held at %0t", $time);
            end
        end else begin
            if (inValid) launchQ.push_back(edgeCnt);
            if (resValid) begin
                assert (expResQ.size() != 0) else begin
                    errCnt++;
                    $display("resValid high at %0t with no beat in flight", $time);
                end
                if (expResQ.size() != 0) begin
                    expRes     = expResQ.pop_front();
                    expFlg     = expFlagQ.pop_front();
                    launchEdge = launchQ.pop_front();
                    assert (result === expRes) else begin
                        errCnt++;
                        $display("ERROR time=%0t signal=result expected=%h actual=%h",
                                 $time, expRes, result);
                    end
                    assert (flags === expFlg) else begin
                        errCnt++;
                        $display("ERROR time=%0t signal=flags expected=%b actual=%b",
                                 $time, expFlg, flags);
                    end
                    assert (edgeCnt == launchEdge + 3) else begin
                        errCnt++;
                        $display("result at %0t came %0d edges after launch instead of 3",
                                 $time, edgeCnt - launchEdge);
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////

    task automatic runTest(input int t);
        int          errBefore;
        logic [63:0] d;
        string       name;
        errBefore = errCnt;
        case (t)
            1: begin
                name = "exact int to fp";
                launch(cvtOpT'(3'b000), RNE, 1'b0, '0, '0, boxS(32'h0), NO_FLAGS);
                launch(cvtOpT'(3'b110), RNE, 1'b1, '0, '0, '0, NO_FLAGS);
                for (int i = 0; i < 24; i++) randomBeat(1'b0);
            end
            2: begin
                name = "fp to int rounding modes";
                for (int f = 0; f < 2; f++) begin
                    for (int m = 0; m < 5; m++) begin
                        for (int i = 0; i < 7; i++) begin
                            d = $realtobits(testVals[i]);
                            launch(cvtOpT'({f[0], 2'b01}), roundModeT'(m), f[0],
                                   f[0] ? d : boxS(toSingle(d)), '0,
                                   dataT'(roundRef(testVals[i], roundModeT'(m))), INEXACT_ONLY);
                        end
                    end
                end
            end
            3: begin
                name = "saturation and invalid";
                launch(cvtOpT'(3'b001), RNE, 1'b1, 64'h7ff0_0000_0000_0000, '0,
                       64'h0000_0000_7fff_ffff, INVALID_ONLY);          // +inf, w
                launch(cvtOpT'(3'b101), RNE, 1'b0, boxS(32'hff80_0000), '0,
                       64'h8000_0000_0000_0000, INVALID_ONLY);          // -inf, l
                launch(cvtOpT'(3'b101), RNE, 1'b1, 64'h7ff8_0000_0000_0000, '0,
                       64'h7fff_ffff_ffff_ffff, INVALID_ONLY);          // NaN, l
                launch(cvtOpT'(3'b011), RNE, 1'b0, boxS(32'h7fc0_0000), '0,
                       64'hffff_ffff_ffff_ffff, INVALID_ONLY);          // NaN, wu
                launch(cvtOpT'(3'b001), RNE, 1'b1, $realtobits(1099511627776.0), '0,
                       64'h0000_0000_7fff_ffff, INVALID_ONLY);          // 2^40, w
                launch(cvtOpT'(3'b011), RNE, 1'b1, $realtobits(-1.0), '0,
                       64'h0, INVALID_ONLY);                            // -1.0, wu
                launch(cvtOpT'(3'b101), RNE, 1'b1, $realtobits(9223372036854775808.0), '0,
                       64'h7fff_ffff_ffff_ffff, INVALID_ONLY);          // 2^63, l
                launch(cvtOpT'(3'b111), RNE, 1'b1, 64'h7ff0_0000_0000_0000, '0,
                       64'hffff_ffff_ffff_ffff, INVALID_ONLY);          // +inf, lu
            end
            4: begin
                name = "inexact int to fp";
                // 2^24+1 is a tie with even lsb
                launch(cvtOpT'(3'b000), RNE, 1'b0, '0, 64'd16777217, boxS(32'h4b80_0000),
                       INEXACT_ONLY);
                launch(cvtOpT'(3'b000), RTZ, 1'b0, '0, 64'd16777217, boxS(32'h4b80_0000),
                       INEXACT_ONLY);
                launch(cvtOpT'(3'b000), RUP, 1'b0, '0, 64'd16777217, boxS(32'h4b80_0001),
                       INEXACT_ONLY);
                // 2^24+3, odd lsb so the tie rounds up
                launch(cvtOpT'(3'b000), RNE, 1'b0, '0, 64'd16777219, boxS(32'h4b80_0002),
                       INEXACT_ONLY);
                launch(cvtOpT'(3'b000), RTZ, 1'b0, '0, 64'd16777219, boxS(32'h4b80_0001),
                       INEXACT_ONLY);
                launch(cvtOpT'(3'b000), RUP, 1'b0, '0, 64'd16777219, boxS(32'h4b80_0002),
                       INEXACT_ONLY);
                // 2^53+1 into double
                launch(cvtOpT'(3'b100), RNE, 1'b1, '0, 64'h0020_0000_0000_0001,
                       64'h4340_0000_0000_0000, INEXACT_ONLY);
                launch(cvtOpT'(3'b100), RTZ, 1'b1, '0, 64'h0020_0000_0000_0001,
                       64'h4340_0000_0000_0000, INEXACT_ONLY);
                launch(cvtOpT'(3'b100), RUP, 1'b1, '0, 64'h0020_0000_0000_0001,
                       64'h4340_0000_0000_0001, INEXACT_ONLY);
            end
            default: begin
                name = "pipeline and reset";
                @(posedge clk);
                rstN <= 1'b0;
                repeat (3) @(posedge clk);
                rstN <= 1'b1;
                repeat (6) @(posedge clk);   // idle, resValid must stay low
                for (int i = 0; i < 20; i++) randomBeat(1'b1);
            end
        endcase
        idle();
        drain();
        if (errCnt == errBefore && !timedOut) begin
            passCnt++;
            $display("test %0d %s: ok", t, name);
        end else begin
            failCnt++;
            $display("test %0d %s: failed", t, name);
        end
    endtask

    initial begin
        rstN    = 1'b0;
        inValid = 1'b0;
        op      = '0;
        frm     = RNE;
        fmt     = 1'b0;
        fpIn    = '0;
        intIn   = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        for (int t = 1; t <= 5 && !timedOut; t++) runTest(t);
        $display("tests passed %0d failed %0d", passCnt, failCnt);
        if (failCnt == 0 && errCnt == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
common/fcvtPkg.sv
design/fpUnpack.sv
fcvt/cvtShiftRound.sv
fcvt/cvtSaturate.sv
design/fcvtUnit.sv
verif/fcvtTb.sv
